// File: list.f
regReadPkg.sv
physRegFile.sv
laneOperandRead.sv
readyTable.sv
regReadStage.sv
tbClock.sv
regRead_checker.sv
regReadTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the register-read stage testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
  --top-module regReadTb \
  -f list.f \
  -o simRegRead

# Keep running past assertion errors so the testbench reaches its verdict
./obj_dir/simRegRead +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "^Simulation completed successfully$" sim.log; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi

// File: regReadTb.sv
/*
  Testbench for the register-read stage
  Random stimulus checked against a shadow file and ready model
*/
`timescale 1ns/1ns

module regReadTb;

  import regReadPkg::*;

  localparam int resetCycles = 10;
  localparam int numCycles = 2000;
  localparam int edgeTimeout = 200;
  localparam int sampleDelay = 40;

  logic clk;
  logic rstN;
  logic [numLanes-1:0] fuValid;
  physTagT [numLanes-1:0] fuSrc1;
  physTagT [numLanes-1:0] fuSrc2;
  maskT [numLanes-1:0] fuMask;
  logic [numLanes-1:0] wbValid;
  physTagT [numLanes-1:0] wbDest;
  dataT [numLanes-1:0] wbData;
  logic [numLanes-1:0] unmapValid;
  physTagT [numLanes-1:0] unmapTag;
  logic [numLanes-1:0] rsrValid;
  physTagT [numLanes-1:0] rsrTag;
  logic ctrlVerified;
  logic ctrlMispredict;
  logic [checkpointW-1:0] ctrlCheckpoint;
  logic recover;
  logic exception;
  logic [numLanes-1:0] fuValidOut;
  dataT [numLanes-1:0] fuData1;
  dataT [numLanes-1:0] fuData2;
  logic [numPhysRegs-1:0] phyRegRdy;

  integer seed;
  int errors;
  int timeouts;

  // Shadow state
  dataT shadowFile [numPhysRegs];
  logic written [numPhysRegs];
  logic [numPhysRegs-1:0] modelReady;

  tbClock clockGen (
    .clk (clk)
  );

  regReadStage regReadStage_i (
    .clk              (clk),
    .rstN_i           (rstN),
    .fuValid_i        (fuValid),
    .fuSrc1_i         (fuSrc1),
    .fuSrc2_i         (fuSrc2),
    .fuMask_i         (fuMask),
    .wbValid_i        (wbValid),
    .wbDest_i         (wbDest),
    .wbData_i         (wbData),
    .unmapValid_i     (unmapValid),
    .unmapTag_i       (unmapTag),
    .rsrValid_i       (rsrValid),
    .rsrTag_i         (rsrTag),
    .ctrlVerified_i   (ctrlVerified),
    .ctrlMispredict_i (ctrlMispredict),
    .ctrlCheckpoint_i (ctrlCheckpoint),
    .recover_i        (recover),
    .exception_i      (exception),
    .fuValid_o        (fuValidOut),
    .fuData1_o        (fuData1),
    .fuData2_o        (fuData2),
    .phyRegRdy_o      (phyRegRdy)
  );

  function automatic logic [31:0] nextRand();
    nextRand = $random(seed);
  endfunction

  // Registers 0 to 31 ready, the rest pending
  function automatic logic [numPhysRegs-1:0] archPattern();
    logic [numPhysRegs-1:0] p;
    for (int i = 0; i < numPhysRegs; i++)
    begin
      p[i] = (i < numArchRegs);
    end
    archPattern = p;
  endfunction

  task automatic waitFallingEdge();
    int waited;
    waited = 0;
    while (clk !== 1'b1 && waited < edgeTimeout)
    begin
      #1;
      waited++;
    end
    while (clk !== 1'b0 && waited < edgeTimeout)
    begin
      #1;
      waited++;
    end
    if (waited >= edgeTimeout)
    begin
      timeouts++;
      $display("Timeout: no falling clock edge within %0d ns", edgeTimeout);
    end
  endtask

  task automatic idleInputs();
    fuValid = '0;
    fuSrc1 = '0;
    fuSrc2 = '0;
    fuMask = '0;
    wbValid = '0;
    wbDest = '0;
    wbData = '0;
    unmapValid = '0;
    unmapTag = '0;
    rsrValid = '0;
    rsrTag = '0;
    ctrlVerified = 1'b0;
    ctrlMispredict = 1'b0;
    ctrlCheckpoint = '0;
    recover = 1'b0;
    exception = 1'b0;
  endtask

  task automatic driveRandom();
    logic [31:0] r;
    physTagT tag;
    logic dup;
    r = nextRand();
    fuValid = r[numLanes-1:0];
    wbValid = r[2*numLanes-1:numLanes];
    unmapValid = r[3*numLanes-1:2*numLanes];
    rsrValid = r[4*numLanes-1:3*numLanes];
    ctrlVerified = r[16];
    ctrlMispredict = r[17];
    ctrlCheckpoint = r[19:18];
    recover = (nextRand() % 32'd10) == 32'd0;
    exception = (nextRand() % 32'd50) == 32'd0;
    // Destinations distinct within the cycle
    for (int k = 0; k < numLanes; k++)
    begin
      dup = 1'b1;
      while (dup)
      begin
        r = nextRand();
        tag = r[physRegW-1:0];
        dup = 1'b0;
        for (int j = 0; j < k; j++)
        begin
          if (wbDest[j] == tag)
          begin
            dup = 1'b1;
          end
        end
      end
      wbDest[k] = tag;
      wbData[k] = nextRand();
    end
    // Half the sources aim at a writeback destination
    for (int k = 0; k < numLanes; k++)
    begin
      r = nextRand();
      fuSrc1[k] = r[0] ? wbDest[r[2:1]] : r[8:3];
      fuSrc2[k] = r[9] ? wbDest[r[11:10]] : r[17:12];
      fuMask[k] = r[21:18];
      unmapTag[k] = r[27:22];
      r = nextRand();
      rsrTag[k] = r[5:0];
    end
  endtask

  task automatic expectOperand(input physTagT tag, output dataT value, output logic known);
    known = written[tag];
    value = shadowFile[tag];
    for (int k = 0; k < numLanes; k++)
    begin
      if (wbValid[k] && wbDest[k] == tag)
      begin
        value = wbData[k];
        known = 1'b1;
      end
    end
  endtask

  task automatic checkOutputs();
    logic [numLanes-1:0] expValid;
    dataT expData;
    logic known;
    for (int k = 0; k < numLanes; k++)
    begin
      expValid[k] = fuValid[k]
        && !(ctrlVerified && ctrlMispredict && fuMask[k][ctrlCheckpoint]);
    end
    if (fuValidOut !== expValid)
    begin
      errors++;
      $display("MISMATCH fuValid_o got %h expected %h", fuValidOut, expValid);
    end
    for (int k = 0; k < numLanes; k++)
    begin
      expectOperand(fuSrc1[k], expData, known);
      if (known && fuData1[k] !== expData)
      begin
        errors++;
        $display("MISMATCH fuData1_o[%0d] got %h expected %h", k, fuData1[k], expData);
      end
      expectOperand(fuSrc2[k], expData, known);
      if (known && fuData2[k] !== expData)
      begin
        errors++;
        $display("MISMATCH fuData2_o[%0d] got %h expected %h", k, fuData2[k], expData);
      end
    end
    if (phyRegRdy !== modelReady)
    begin
      errors++;
      $display("MISMATCH phyRegRdy_o got %h expected %h", phyRegRdy, modelReady);
    end
  endtask

  // Model of the rising edge
  task automatic updateModel();
    if (!recover)
    begin
      for (int k = 0; k < numLanes; k++)
      begin
        if (wbValid[k])
        begin
          shadowFile[wbDest[k]] = wbData[k];
          written[wbDest[k]] = 1'b1;
        end
      end
    end
    if (exception)
    begin
      modelReady = archPattern();
    end
    else
    begin
      for (int k = 0; k < numLanes; k++)
      begin
        if (unmapValid[k])
        begin
          modelReady[unmapTag[k]] = 1'b0;
        end
      end
      for (int k = 0; k < numLanes; k++)
      begin
        if (rsrValid[k])
        begin
          modelReady[rsrTag[k]] = 1'b1;
        end
      end
    end
  endtask

  initial
  begin
    seed = 32'hb5b2_9e8c;
    errors = 0;
    timeouts = 0;
    rstN = 1'b0;
    idleInputs();
    for (int i = 0; i < numPhysRegs; i++)
    begin
      shadowFile[i] = '0;
      written[i] = 1'b0;
    end
    modelReady = archPattern();
    for (int c = 0; c < resetCycles && timeouts == 0; c++)
    begin
      waitFallingEdge();
    end
    rstN = 1'b1;
    for (int c = 0; c < numCycles && timeouts == 0; c++)
    begin
      driveRandom();
      #sampleDelay;
      checkOutputs();
      updateModel();
      waitFallingEdge();
    end
    $display("Run finished with %0d mismatches and %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0)
    begin
      $display("Simulation completed successfully");
    end
    else
    begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: regRead_checker.sv
/*
  Concurrent assertions on the register-read stage, bound to the top level
*/
`timescale 1ns/1ns

module regRead_checker (
  input logic                                            clk,
  input logic                                            rstN_i,
  input logic [regReadPkg::numLanes-1:0]                 fuValid_i,
  input regReadPkg::maskT [regReadPkg::numLanes-1:0]     fuMask_i,
  input logic                                            ctrlVerified_i,
  input logic                                            ctrlMispredict_i,
  input logic [regReadPkg::checkpointW-1:0]              ctrlCheckpoint_i,
  input logic [regReadPkg::numLanes-1:0]                 fuValid_o,
  input logic [regReadPkg::numPhysRegs-1:0]              phyRegRdy_o
);

  import regReadPkg::*;

  // Output valid only narrows the input valid
  assert property (@(posedge clk) disable iff (!rstN_i) (fuValid_o & ~fuValid_i) == '0)
    else $error("fuValid_o high on a lane whose fuValid_i is low");

  for (genvar k = 0; k < numLanes; k++)
  begin : genSquash
    assert property (@(posedge clk) disable iff (!rstN_i)
      (ctrlVerified_i && ctrlMispredict_i && fuMask_i[k][ctrlCheckpoint_i]) |-> !fuValid_o[k])
      else $error("lane %0d kept its valid on a verified mispredict", k);
  end

  // Architectural entries ready right after reset
  assert property (@(posedge clk) $rose(rstN_i) |-> &phyRegRdy_o[numArchRegs-1:0])
    else $error("architectural ready bits not set after reset");

endmodule

bind regReadStage regRead_checker regReadChk (
  .clk              (clk),
  .rstN_i           (rstN_i),
  .fuValid_i        (fuValid_i),
  .fuMask_i         (fuMask_i),
  .ctrlVerified_i   (ctrlVerified_i),
  .ctrlMispredict_i (ctrlMispredict_i),
  .ctrlCheckpoint_i (ctrlCheckpoint_i),
  .fuValid_o        (fuValid_o),
  .phyRegRdy_o      (phyRegRdy_o)
);

// File: tbClock.sv
/*
  Testbench clock, 100 ns period
*/
`timescale 1ns/1ns

module tbClock (
  output logic clk
);

  localparam int halfPeriod = 50;

  initial
  begin
    clk = 1'b0;
  end

  always #halfPeriod clk = ~clk;

endmodule

// File: regReadStage.sv
/*
  Register-read stage of a four-wide out-of-order core
  Register file, per-lane bypass and squash, and the ready bitmap
*/
`timescale 1ns/1ns

module regReadStage (
  input  logic                                            clk,
  input  logic                                            rstN_i,
  input  logic [regReadPkg::numLanes-1:0]                 fuValid_i,
  input  regReadPkg::physTagT [regReadPkg::numLanes-1:0]  fuSrc1_i,
  input  regReadPkg::physTagT [regReadPkg::numLanes-1:0]  fuSrc2_i,
  input  regReadPkg::maskT [regReadPkg::numLanes-1:0]     fuMask_i,
  input  logic [regReadPkg::numLanes-1:0]                 wbValid_i,
  input  regReadPkg::physTagT [regReadPkg::numLanes-1:0]  wbDest_i,
  input  regReadPkg::dataT [regReadPkg::numLanes-1:0]     wbData_i,
  input  logic [regReadPkg::numLanes-1:0]                 unmapValid_i,
  input  regReadPkg::physTagT [regReadPkg::numLanes-1:0]  unmapTag_i,
  input  logic [regReadPkg::numLanes-1:0]                 rsrValid_i,
  input  regReadPkg::physTagT [regReadPkg::numLanes-1:0]  rsrTag_i,
  input  logic                                            ctrlVerified_i,
  input  logic                                            ctrlMispredict_i,
  input  logic [regReadPkg::checkpointW-1:0]              ctrlCheckpoint_i,
  input  logic                                            recover_i,
  input  logic                                            exception_i,
  output logic [regReadPkg::numLanes-1:0]                 fuValid_o,
  output regReadPkg::dataT [regReadPkg::numLanes-1:0]     fuData1_o,
  output regReadPkg::dataT [regReadPkg::numLanes-1:0]     fuData2_o,
  output logic [regReadPkg::numPhysRegs-1:0]              phyRegRdy_o
);

  import regReadPkg::*;

  physTagT [2*numLanes-1:0] readTag;
  dataT [2*numLanes-1:0]    readData;
  logic [numLanes-1:0]      writeEn;

  // No file writes while recovering
  assign writeEn = wbValid_i & ~{numLanes{recover_i}};

  physRegFile regFile (
    .clk         (clk),
    .writeEn_i   (writeEn),
    .writeTag_i  (wbDest_i),
    .writeData_i (wbData_i),
    .readTag_i   (readTag),
    .readData_o  (readData)
  );

  for (genvar k = 0; k < numLanes; k++)
  begin : genLane
    assign readTag[2*k]   = fuSrc1_i[k];
    assign readTag[2*k+1] = fuSrc2_i[k];

    laneOperandRead lane (
      .src1_i           (fuSrc1_i[k]),
      .src2_i           (fuSrc2_i[k]),
      .fileData1_i      (readData[2*k]),
      .fileData2_i      (readData[2*k+1]),
      .valid_i          (fuValid_i[k]),
      .mask_i           (fuMask_i[k]),
      .wbValid_i        (wbValid_i),
      .wbDest_i         (wbDest_i),
      .wbData_i         (wbData_i),
      .ctrlVerified_i   (ctrlVerified_i),
      .ctrlMispredict_i (ctrlMispredict_i),
      .ctrlCheckpoint_i (ctrlCheckpoint_i),
      .valid_o          (fuValid_o[k]),
      .data1_o          (fuData1_o[k]),
      .data2_o          (fuData2_o[k])
    );
  end

  readyTable readyBits (
    .clk          (clk),
    .rstN_i       (rstN_i),
    .exception_i  (exception_i),
    .unmapValid_i (unmapValid_i),
    .unmapTag_i   (unmapTag_i),
    .rsrValid_i   (rsrValid_i),
    .rsrTag_i     (rsrTag_i),
    .ready_o      (phyRegRdy_o)
  );

endmodule

// File: readyTable.sv
/*
  Physical register ready bitmap
  Cleared on unmap, set on result tags, reinitialized on reset and exception
*/
`timescale 1ns/1ns

module readyTable (
  input  logic                                            clk,
  input  logic                                            rstN_i,
  input  logic                                            exception_i,
  input  logic [regReadPkg::numLanes-1:0]                 unmapValid_i,
  input  regReadPkg::physTagT [regReadPkg::numLanes-1:0]  unmapTag_i,
  input  logic [regReadPkg::numLanes-1:0]                 rsrValid_i,
  input  regReadPkg::physTagT [regReadPkg::numLanes-1:0]  rsrTag_i,
  output logic [regReadPkg::numPhysRegs-1:0]              ready_o
);

  import regReadPkg::*;

  logic [numPhysRegs-1:0] readyQ;
  logic [numPhysRegs-1:0] readyNext;

  // Clears first, so a set on the same entry wins
  always_comb
  begin
    readyNext = readyQ;
    for (int k = 0; k < numLanes; k++)
    begin
      if (unmapValid_i[k])
      begin
        readyNext[unmapTag_i[k]] = 1'b0;
      end
    end
    for (int k = 0; k < numLanes; k++)
    begin
      if (rsrValid_i[k])
      begin
        readyNext[rsrTag_i[k]] = 1'b1;
      end
    end
  end

  // Architectural entries ready, renamed ones pending
  always_ff @(posedge clk or negedge rstN_i)
  begin
    if (!rstN_i)
    begin
      for (int i = 0; i < numPhysRegs; i++)
      begin
        readyQ[i] <= (i < numArchRegs);
      end
    end
    else if (exception_i)
    begin
      for (int i = 0; i < numPhysRegs; i++)
      begin
        readyQ[i] <= (i < numArchRegs);
      end
    end
    else
    begin
      readyQ <= readyNext;
    end
  end

  assign ready_o = readyQ;

endmodule

// File: laneOperandRead.sv
/*
  Operand read for one issue lane
  Writeback bypass per source and squash of the valid on a mispredict
*/
`timescale 1ns/1ns

module laneOperandRead (
  input  regReadPkg::physTagT                             src1_i,
  input  regReadPkg::physTagT                             src2_i,
  input  regReadPkg::dataT                                fileData1_i,
  input  regReadPkg::dataT                                fileData2_i,
  input  logic                                            valid_i,
  input  regReadPkg::maskT                                mask_i,
  input  logic [regReadPkg::numLanes-1:0]                 wbValid_i,
  input  regReadPkg::physTagT [regReadPkg::numLanes-1:0]  wbDest_i,
  input  regReadPkg::dataT [regReadPkg::numLanes-1:0]     wbData_i,
  input  logic                                            ctrlVerified_i,
  input  logic                                            ctrlMispredict_i,
  input  logic [regReadPkg::checkpointW-1:0]              ctrlCheckpoint_i,
  output logic                                            valid_o,
  output regReadPkg::dataT                                data1_o,
  output regReadPkg::dataT                                data2_o
);

  import regReadPkg::*;

  logic [numLanes-1:0] match1;
  logic [numLanes-1:0] match2;
  logic squash;

  // One-hot, since writeback destinations differ within a cycle
  always_comb
  begin
    for (int k = 0; k < numLanes; k++)
    begin
      match1[k] = wbValid_i[k] && (wbDest_i[k] == src1_i);
      match2[k] = wbValid_i[k] && (wbDest_i[k] == src2_i);
    end
  end

  // File value unless a writeback lane hits
  always_comb
  begin
    data1_o = fileData1_i;
    data2_o = fileData2_i;
    for (int k = 0; k < numLanes; k++)
    begin
      if (match1[k])
      begin
        data1_o = wbData_i[k];
      end
      if (match2[k])
      begin
        data2_o = wbData_i[k];
      end
    end
  end

  // Kill instructions younger than the mispredicted branch
  assign squash = ctrlVerified_i && ctrlMispredict_i && mask_i[ctrlCheckpoint_i];
  assign valid_o = valid_i && !squash;

endmodule

// File: physRegFile.sv
/*
  Physical register file, 64 entries
  Four write ports at the rising edge, eight combinational read ports
*/
`timescale 1ns/1ns

module physRegFile (
  input  logic                                              clk,
  input  logic [regReadPkg::numLanes-1:0]                   writeEn_i,
  input  regReadPkg::physTagT [regReadPkg::numLanes-1:0]    writeTag_i,
  input  regReadPkg::dataT [regReadPkg::numLanes-1:0]       writeData_i,
  input  regReadPkg::physTagT [2*regReadPkg::numLanes-1:0]  readTag_i,
  output regReadPkg::dataT [2*regReadPkg::numLanes-1:0]     readData_o
);

  import regReadPkg::*;

  // Storage array, models an SRAM macro
  dataT regFile [numPhysRegs];

  // Write ports never target the same entry in one cycle
  always_ff @(posedge clk)
  begin
    for (int k = 0; k < numLanes; k++)
    begin
      if (writeEn_i[k])
      begin
        regFile[writeTag_i[k]] <= writeData_i[k];
      end
    end
  end

  // Port 2k is source 1 of lane k, port 2k+1 is source 2
  always_comb
  begin
    for (int p = 0; p < 2*numLanes; p++)
    begin
      readData_o[p] = regFile[readTag_i[p]];
    end
  end

endmodule

// File: regReadPkg.sv
/*
  Register-read stage package
  Sizes and common types shared by the file, the lanes and the ready table
*/
package regReadPkg;

  // Issue and writeback width of the core
  localparam int numLanes = 4;

  // Physical register file
  localparam int numPhysRegs = 64;
  localparam int physRegW = $clog2(numPhysRegs);

  // Operand width
  localparam int dataW = 32;

  // Entries that hold architectural state out of reset
  localparam int numArchRegs = 32;

  // Branch checkpoints, one mask bit each
  localparam int numCheckpoints = 4;
  localparam int checkpointW = $clog2(numCheckpoints);

  // Physical register tag
  typedef logic [physRegW-1:0] physTagT;

  // Operand value
  typedef logic [dataW-1:0] dataT;

  // Checkpoints an instruction depends on
  typedef logic [numCheckpoints-1:0] maskT;

endpackage
